// File: common/noc_pkg.sv
// router port count, flit field widths and shared fabric types.

package noc_pkg;

        // ********************
        // router geometry
        // ********************

        localparam int PORTS  = 5;      // north, east, south, west, local.
        localparam int DATA_W = 32;     // flit payload.
        localparam int VCH_W  = 2;      // four virtual channels.
        localparam int PORT_W = 3;      // encoded port number.

        // ********************
        // flit fields
        // ********************

        // one flit's data word.
        typedef logic [DATA_W-1:0] flit_data_t;

        // virtual-channel number carried alongside the flit.
        typedef logic [VCH_W-1:0] vch_t;

        // encoded destination port; codes PORTS and above name no port.
        typedef logic [PORT_W-1:0] port_id_t;

        // ********************
        // fabric vectors
        // ********************

        // one bit per port.
        // used for request rows, grant rows and returned grants.
        typedef logic [PORTS-1:0] port_vec_t;

endpackage

// File: common/xbar_fabric_if.sv
// crossbar fabric interface with the flit, request and grant matrices.

`timescale 1ns/1ps

interface xbar_fabric_if
        import noc_pkg::*;
        ();

        flit_data_t data [PORTS];       // indexed by input.
        port_vec_t  valid;              // one bit per input.
        vch_t       vch  [PORTS];       // indexed by input.
        port_vec_t  req  [PORTS];       // row per output, bit per input.
        port_vec_t  grt  [PORTS];       // row per output, bit per input.

        // route decoder side.
        modport decoder (
                output data,
                output valid,
                output vch,
                output req,
                input  grt
        );

        // output port side; each instance drives only its own grant row.
        modport port (
                input  data,
                input  valid,
                input  vch,
                input  req,
                output grt
        );

endinterface

// File: crossbar/xbar_route_decode.sv
// route decoder building the request matrix and transposing grants back to the inputs.

`timescale 1ns/1ps

module xbar_route_decode
        import noc_pkg::*;
        (
        input  flit_data_t    idata  [PORTS],
        input  port_vec_t     ivalid,
        input  vch_t          ivch   [PORTS],
        input  port_id_t      port   [PORTS],
        input  port_vec_t     req,
        output port_vec_t     grt    [PORTS],
        xbar_fabric_if.decoder fabric
);

        // ********************
        // flit forwarding
        // ********************

        always_comb begin
                for (int i = 0; i < PORTS; i++) begin
                        fabric.data[i] = idata[i];
                        fabric.vch[i]  = ivch[i];
                end
                fabric.valid = ivalid;
        end

        // ********************
        // request matrix
        // ********************

        // a port code of PORTS or above matches no row and is dropped.
        always_comb begin
                for (int o = 0; o < PORTS; o++) begin
                        for (int i = 0; i < PORTS; i++) begin
                                fabric.req[o][i] = req[i] && (port[i] == PORT_W'(o));
                        end
                end
        end

        // ********************
        // grant return
        // ********************

        // output rows become input rows.
        always_comb begin
                for (int i = 0; i < PORTS; i++) begin
                        for (int o = 0; o < PORTS; o++) begin
                                grt[i][o] = fabric.grt[o][i];
                        end
                end
        end

endmodule

// File: crossbar/xbar_out_port.sv
// output port with a round-robin packet-locking arbiter and its flit multiplexer.

`timescale 1ns/1ps

module xbar_out_port
        import noc_pkg::*;
        #(
        parameter int OUT_ID = 0
        ) (
        input  logic          clk,
        input  logic          reset,
        xbar_fabric_if.port   fabric,
        output flit_data_t    odata,
        output logic          ovalid,
        output vch_t          ovch
);

        port_vec_t            row;            // requests aimed at this output.
        port_vec_t            grant;          // registered owner, one-hot.
        port_vec_t            grant_next;
        logic [PORT_W-1:0]    ptr;            // highest-priority input.
        logic [PORT_W-1:0]    ptr_next;

        assign row = fabric.req[OUT_ID];

        // ********************
        // arbiter
        // ********************

        always_comb begin : pick
                int   idx;
                logic found;

                grant_next = '0;
                ptr_next   = ptr;
                found      = 1'b0;
                idx        = 0;

                if (|(grant & row)) begin
                        grant_next = grant;     // owner still holds its packet.
                end else begin
                        for (int k = 0; k < PORTS; k++) begin
                                idx = int'(ptr) + k;
                                if (idx >= PORTS)
                                        idx = idx - PORTS;
                                if (!found && row[idx]) begin
                                        found           = 1'b1;
                                        grant_next[idx] = 1'b1;
                                        // winner drops to lowest priority.
                                        if (idx == PORTS - 1)
                                                ptr_next = '0;
                                        else
                                                ptr_next = PORT_W'(idx + 1);
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        grant <= '0;
                        ptr   <= '0;
                end else begin
                        grant <= grant_next;
                        ptr   <= ptr_next;
                end
        end

        assign fabric.grt[OUT_ID] = grant;

        // ********************
        // flit multiplexer
        // ********************

        // ovalid stays low without an owner.
        always_comb begin
                odata  = '0;
                ovalid = 1'b0;
                ovch   = '0;
                for (int i = 0; i < PORTS; i++) begin
                        if (grant[i]) begin
                                odata  = fabric.data[i];
                                ovalid = fabric.valid[i];
                                ovch   = fabric.vch[i];
                        end
                end
        end

endmodule

// File: rtl/noc_crossbar_top.sv
// crossbar top level with the route decoder and five output ports.

`timescale 1ns/1ps

module noc_crossbar_top
        import noc_pkg::*;
        (
        input  logic          clk,
        input  logic          reset,

        // input side, one entry per input port.
        input  flit_data_t    idata  [PORTS],
        input  port_vec_t     ivalid,
        input  vch_t          ivch   [PORTS],
        input  port_id_t      port   [PORTS],
        input  port_vec_t     req,
        output port_vec_t     grt    [PORTS],

        // output side, one entry per output port.
        output flit_data_t    odata  [PORTS],
        output port_vec_t     ovalid,
        output vch_t          ovch   [PORTS]
);

        // ********************
        // fabric
        // ********************

        xbar_fabric_if fabric ();

        xbar_route_decode u_route_decode (
                .idata  ( idata  ),
                .ivalid ( ivalid ),
                .ivch   ( ivch   ),
                .port   ( port   ),
                .req    ( req    ),
                .grt    ( grt    ),
                .fabric ( fabric )
        );

        // ********************
        // output ports
        // ********************

        // one arbiter and mux per output.
        for (genvar g = 0; g < PORTS; g++) begin : gen_out

                xbar_out_port #(
                        .OUT_ID ( g )
                ) u_out_port (
                        .clk    ( clk       ),
                        .reset  ( reset     ),
                        .fabric ( fabric    ),
                        .odata  ( odata[g]  ),
                        .ovalid ( ovalid[g] ),
                        .ovch   ( ovch[g]   )
                );

        end

endmodule

// File: sim/tb_clock_gen.sv
// clock and reset generator for the crossbar testbench.

`timescale 1ns/1ps

module tb_clock_gen (
        output logic clk,
        output logic reset
);

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;         // 20 ns period.
        end

        initial begin
                reset = 1'b1;
                repeat (4) @(posedge clk);
                reset <= 1'b0;
        end

endmodule

// File: sim/crossbar_assertions.sv
// bound checks on one-hot grant rows and request-backed grants.

`timescale 1ns/1ps

module crossbar_assertions
        import noc_pkg::*;
        (
        input  logic          clk,
        input  logic          reset,
        input  port_vec_t     req,
        input  port_id_t      port   [PORTS],
        input  port_vec_t     grt    [PORTS]
);

        port_vec_t col [PORTS];         // grants seen per output.

        always_comb begin
                for (int o = 0; o < PORTS; o++) begin
                        for (int i = 0; i < PORTS; i++) begin
                                col[o][i] = grt[i][o];
                        end
                end
        end

        // ********************
        // one owner per output
        // ********************

        for (genvar o = 0; o < PORTS; o++) begin : gen_out
                a_out_onehot: assert property (@(posedge clk) disable iff (reset)
                        $onehot0(col[o]))
                        else $error("output %0d granted to more than one input", o);
        end

        // ********************
        // per-input grants
        // ********************

        for (genvar i = 0; i < PORTS; i++) begin : gen_in
                a_in_onehot: assert property (@(posedge clk) disable iff (reset)
                        $onehot0(grt[i]))
                        else $error("input %0d holds more than one grant", i);

                // grant needs last cycle's request for that output.
                for (genvar o = 0; o < PORTS; o++) begin : gen_bit
                        a_held_req: assert property (@(posedge clk) disable iff (reset)
                                grt[i][o] |-> ($past(req[i]) && $past(port[i]) == PORT_W'(o)))
                                else $error("input %0d granted output %0d without request", i, o);
                end
        end

endmodule

bind noc_crossbar_top crossbar_assertions u_assertions (
        .clk   ( clk   ),
        .reset ( reset ),
        .req   ( req   ),
        .port  ( port  ),
        .grt   ( grt   )
);

// File: sim/tb_crossbar.sv
// crossbar testbench with lfsr stimulus, arbiter model, compare tasks and timeout.

`timescale 1ns/1ps

module tb_crossbar
        import noc_pkg::*;
        ();

        localparam int TEST_CYCLES  = 2000;
        localparam int RESET_CYCLES = 4;
        localparam int LIMIT        = RESET_CYCLES + TEST_CYCLES + 200;
        localparam int MAX_LEN      = 8;
        localparam int STARVE_LIMIT = (PORTS - 1) * (MAX_LEN + 1) + 1;

        logic       clk;
        logic       reset;
        flit_data_t idata  [PORTS] = '{default: '0};
        port_vec_t  ivalid         = '0;
        vch_t       ivch   [PORTS] = '{default: '0};
        port_id_t   port   [PORTS] = '{default: '0};
        port_vec_t  req            = '0;
        port_vec_t  grt    [PORTS];
        flit_data_t odata  [PORTS];
        port_vec_t  ovalid;
        vch_t       ovch   [PORTS];

        logic [31:0] lfsr_state = 32'hc08c;
        int          remain      [PORTS] = '{default: 0};   // cycles left in packet.
        port_vec_t   model_grant [PORTS] = '{default: '0};  // row per output.
        int          model_ptr   [PORTS] = '{default: 0};
        int          wait_count  [PORTS] = '{default: 0};
        port_vec_t   grant_seen          = '0;
        int          cycles              = 0;

        tb_clock_gen u_clock (.clk(clk), .reset(reset));

        noc_crossbar_top dut0 (
                .clk    ( clk    ),
                .reset  ( reset  ),
                .idata  ( idata  ),
                .ivalid ( ivalid ),
                .ivch   ( ivch   ),
                .port   ( port   ),
                .req    ( req    ),
                .grt    ( grt    ),
                .odata  ( odata  ),
                .ovalid ( ovalid ),
                .ovch   ( ovch   )
        );

        // ********************
        // helpers
        // ********************

        function automatic logic [31:0] lfsr_next(logic [31:0] s);
                return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
        endfunction

        task automatic take_bits(input int n, output logic [31:0] bits);
                bits = '0;
                for (int k = 0; k < n; k++) begin
                        bits       = {bits[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_next(lfsr_state);
                end
        endtask

        task automatic stop_on_error(input string msg);
                $display("%s", msg);
                $display("Testbench failed");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic compare_grant(input int idx, input port_vec_t got, input port_vec_t exp);
                if (got !== exp)
                        stop_on_error($sformatf("** Error at %0t ns: grt[%0d] is %b, expected %b",
                                $time, idx, got, exp));
        endtask

        task automatic compare_data(input int idx, input flit_data_t got, input flit_data_t exp);
                if (got !== exp)
                        stop_on_error($sformatf("** Error at %0t ns: odata[%0d] is %h, expected %h",
                                $time, idx, got, exp));
        endtask

        task automatic compare_vch(input int idx, input vch_t got, input vch_t exp);
                if (got !== exp)
                        stop_on_error($sformatf("** Error at %0t ns: ovch[%0d] is %0d, expected %0d",
                                $time, idx, got, exp));
        endtask

        task automatic compare_valid(input int idx, input logic got, input logic exp);
                if (got !== exp)
                        stop_on_error($sformatf("** Error at %0t ns: ovalid[%0d] is %b, expected %b",
                                $time, idx, got, exp));
        endtask

        // ********************
        // stimulus
        // ********************

        always @(posedge clk) begin : drive
                logic [31:0] r;

                for (int i = 0; i < PORTS; i++) begin
                        take_bits(32, r);
                        idata[i] <= r;
                        take_bits(1, r);
                        ivalid[i] <= r[0];
                        if (reset) begin
                                remain[i] = 0;
                                req[i]   <= 1'b0;
                        end else if (remain[i] > 1) begin
                                remain[i]--;
                        end else if (remain[i] == 1) begin
                                remain[i] = 0;          // last flit sent, idle one cycle.
                                req[i]   <= 1'b0;
                        end else begin
                                take_bits(1, r);
                                if (r[0]) begin
                                        take_bits(3, r);
                                        port[i] <= r[2:0];      // 5..7 name no port.
                                        take_bits(2, r);
                                        ivch[i] <= r[1:0];
                                        take_bits(3, r);
                                        remain[i] = int'(r[2:0]) + 1;
                                        req[i]   <= 1'b1;
                                end
                        end
                end
        end

        // ********************
        // model and checks
        // ********************

        always @(negedge clk) begin : check
                port_vec_t exp_row;
                port_vec_t row;
                port_vec_t next_row;
                int        idx;
                int        src;
                logic      found;

                for (int i = 0; i < PORTS; i++) begin
                        for (int o = 0; o < PORTS; o++)
                                exp_row[o] = model_grant[o][i];
                        compare_grant(i, grt[i], exp_row);
                        if (grt[i] != '0)
                                grant_seen[i] = 1'b1;
                        if (req[i] && int'(port[i]) < PORTS && grt[i] == '0)
                                wait_count[i]++;
                        else
                                wait_count[i] = 0;
                        if (wait_count[i] > STARVE_LIMIT)
                                stop_on_error($sformatf("input %0d starved for %0d cycles",
                                        i, wait_count[i]));
                end

                for (int o = 0; o < PORTS; o++) begin
                        src = -1;
                        for (int i = 0; i < PORTS; i++)
                                if (model_grant[o][i])
                                        src = i;
                        if (src >= 0) begin
                                compare_data(o, odata[o], idata[src]);
                                compare_vch(o, ovch[o], ivch[src]);
                                compare_valid(o, ovalid[o], ivalid[src]);
                        end else begin
                                compare_valid(o, ovalid[o], 1'b0);
                        end
                end

                // state for the next edge.
                for (int o = 0; o < PORTS; o++) begin
                        for (int i = 0; i < PORTS; i++)
                                row[i] = req[i] && (int'(port[i]) == o);
                        next_row = '0;
                        found    = 1'b0;
                        if (reset) begin
                                model_ptr[o] = 0;
                        end else if ((model_grant[o] & row) != '0) begin
                                next_row = model_grant[o];      // packet lock.
                        end else begin
                                for (int k = 0; k < PORTS; k++) begin
                                        idx = (model_ptr[o] + k) % PORTS;
                                        if (!found && row[idx]) begin
                                                found         = 1'b1;
                                                next_row[idx] = 1'b1;
                                                model_ptr[o]  = (idx + 1) % PORTS;
                                        end
                                end
                        end
                        model_grant[o] = next_row;
                end
        end

        // ********************
        // run control
        // ********************

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= LIMIT)
                        stop_on_error($sformatf("timeout: run passed %0d cycles", LIMIT));
        end

        initial begin
                @(negedge reset);
                repeat (TEST_CYCLES) @(posedge clk);
                if (grant_seen != '1) begin
                        stop_on_error($sformatf("some inputs were never granted: %b", grant_seen));
                end else begin
                        $display("Testbench passed");
                        $finish;
                end
        end

endmodule

// File: src.f
common/noc_pkg.sv
common/xbar_fabric_if.sv
crossbar/xbar_route_decode.sv
crossbar/xbar_out_port.sv
rtl/noc_crossbar_top.sv
sim/tb_clock_gen.sv
sim/crossbar_assertions.sv
sim/tb_crossbar.sv

// File: Makefile
# Verilator build and run of the crossbar testbench.

TOP := tb_crossbar
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f src.f
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
